//--- test/tuple_stimulus.txt
// Columns: field 0 (bits 31:0) up to field 15 (bits 511:480), all hex
// Last column: expected sum of the sixteen fields modulo 2^32, hex
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff fffffff0
00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008 00000009 0000000a 0000000b 0000000c 0000000d 0000000e 0000000f 00000010 00000088
10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 00000000
80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 00000000
11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111110
00000000 01000000 02000000 03000000 04000000 05000000 06000000 07000000 08000000 09000000 0a000000 0b000000 0c000000 0d000000 0e000000 0f000000 78000000
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000000
0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 0000ffff 000ffff0
12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 23456780
deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef eadbeef0
7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff fffffff0
ffffffff 00000002 ffffffff 00000002 ffffffff 00000002 ffffffff 00000002 ffffffff 00000002 ffffffff 00000002 ffffffff 00000002 ffffffff 00000002 00000008
00000001 00000002 00000004 00000008 00000010 00000020 00000040 00000080 00000100 00000200 00000400 00000800 00001000 00002000 00004000 00008000 0000ffff
00010000 00020000 00040000 00080000 00100000 00200000 00400000 00800000 01000000 02000000 04000000 08000000 10000000 20000000 40000000 80000000 ffff0000
f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 f0000000 00000000
0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff 0fffffff fffffff0
10000000 20000000 30000000 40000000 50000000 60000000 70000000 80000000 90000000 a0000000 b0000000 c0000000 d0000000 e0000000 f0000000 00000000 80000000
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000010
aaaaaaaa aaaaaaaa aaaaaaaa aaaaaaaa aaaaaaaa aaaaaaaa aaaaaaaa aaaaaaaa 55555555 55555555 55555555 55555555 55555555 55555555 55555555 55555555 fffffff8
a5a5a5a0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a0
00000000 a5a5a5a1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a1
00000000 00000000 a5a5a5a2 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a2
00000000 00000000 00000000 a5a5a5a3 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a3
00000000 00000000 00000000 00000000 a5a5a5a4 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a4
00000000 00000000 00000000 00000000 00000000 a5a5a5a5 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a5
00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a6 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a6
00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a7 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a7
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a8 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a8
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a9 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5a9
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5aa 00000000 00000000 00000000 00000000 00000000 a5a5a5aa
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5ab 00000000 00000000 00000000 00000000 a5a5a5ab
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5ac 00000000 00000000 00000000 a5a5a5ac
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5ad 00000000 00000000 a5a5a5ad
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5ae 00000000 a5a5a5ae
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 a5a5a5af a5a5a5af

//--- user_logic_c0.f
design/tuple_pkg.sv
design/axis_reg_slice.sv
design/tuple_sum_pipe.sv
design/user_logic_c0.sv
test/user_logic_c0_chk.sv
test/tb_user_logic_c0.sv

//--- Makefile
TOP := tb_user_logic_c0

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f user_logic_c0.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- test/tb_user_logic_c0.sv
`timescale 1ns/10ps

module tb_user_logic_c0
    import tuple_pkg::*;
();

    localparam int    num_tuples   = 36;
    localparam int    line_words   = tuple_lanes + 1;
    localparam string stim_file    = "test/tuple_stimulus.txt";
    localparam int    wait_limit   = 200;
    localparam int    stall_pct    = 50;
    localparam int    stall_cycles = 16;
    localparam int    latency      = 6;
    localparam int    drain_cycles = 20;

    logic                   aclk;
    logic                   rst_n;
    logic                   sink_valid;
    logic                   sink_ready;
    logic [tuple_width-1:0] sink_data;
    logic                   src_valid;
    logic                   src_ready;
    logic [field_width-1:0] src_data;

    // Raw file words, then the tuples and sums unpacked from them
    field_t      stim_mem [num_tuples*line_words];
    tuple_word_u tuple_in [num_tuples];
    field_t      sum_exp  [num_tuples];

    // Handshake and output record of one phase
    int     hs_cycle  [$];
    int     out_cycle [$];
    field_t out_sum   [$];
    int     cycle = 0;
    logic   saw_full;

    user_logic_c0 #(
        .lanes (tuple_lanes)
    ) UUT (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .sink_valid (sink_valid),
        .sink_ready (sink_ready),
        .sink_data  (sink_data),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .src_data   (src_data)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Edge count read at the same edges as the handshakes
    always @(posedge aclk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_sum(input string name, input field_t expected, input field_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected 0x%h actual 0x%h",
                                name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected 0x%h actual 0x%h",
                                name, expected, actual));
        end
    endtask

    task automatic load_stimulus();
        field_t total;
        // Address dependent fill for words the file leaves out
        for (int a = 0; a < num_tuples * line_words; a++) begin
            stim_mem[a] = (field_t'(a) * 32'h9e3779b9) ^ 32'h5bd1e995;
        end
        $readmemh(stim_file, stim_mem);
        for (int t = 0; t < num_tuples; t++) begin
            total = '0;
            for (int l = 0; l < tuple_lanes; l++) begin
                tuple_in[t].field[l] = stim_mem[t*line_words+l];
                total = total + stim_mem[t*line_words+l];
            end
            sum_exp[t] = stim_mem[t*line_words+tuple_lanes];
            if (total !== sum_exp[t]) begin
                abort_run($sformatf("stimulus line %0d has a sum that does not match its fields",
                                    t));
            end
        end
    endtask

    // Presents the tuples in file order and the next one right after each handshake
    task automatic drive_tuples();
        int waited;
        for (int t = 0; t < num_tuples; t++) begin
            sink_valid <= 1'b1;
            sink_data  <= tuple_in[t].raw;
            waited = 0;
            @(posedge aclk);
            while (!sink_ready) begin
                waited++;
                if (waited > wait_limit) begin
                    abort_run($sformatf("tuple %0d was never accepted on the input stream", t));
                end
                @(posedge aclk);
            end
            hs_cycle.push_back(cycle);
        end
        sink_valid <= 1'b0;
        sink_data  <= '0;
    endtask

    task automatic collect_sums(input int count, input logic random_ready);
        int waited;
        int got;
        int n;
        waited = 0;
        got    = 0;
        n      = 0;
        while (got < count) begin
            if (!random_ready) begin
                src_ready <= 1'b1;
            end else if (n < stall_cycles) begin
                // Long stall first so the whole pipeline fills
                src_ready <= 1'b0;
            end else begin
                src_ready <= (($urandom % 100) >= stall_pct);
            end
            n++;
            @(posedge aclk);
            if (random_ready && sink_valid && !sink_ready) begin
                saw_full = 1'b1;
            end
            if (src_valid && src_ready) begin
                out_sum.push_back(src_data);
                out_cycle.push_back(cycle);
                got++;
                waited = 0;
            end else begin
                waited++;
                if (waited > wait_limit) begin
                    abort_run($sformatf("output %0d never arrived on the output stream", got));
                end
            end
        end
        src_ready <= 1'b1;
    endtask

    // Nothing more may come out once every tuple has returned
    task automatic expect_idle();
        for (int c = 0; c < drain_cycles; c++) begin
            @(posedge aclk);
            if (src_valid) begin
                abort_run("an extra output appeared after all tuples had returned");
            end
        end
    endtask

    task automatic check_phase(input logic random_ready);
        for (int i = 0; i < num_tuples; i++) begin
            check_sum($sformatf("src_data[%0d]", i), sum_exp[i], out_sum[i]);
            if (!random_ready && out_cycle[i] - hs_cycle[i] != latency) begin
                abort_run($sformatf("tuple %0d returned %0d cycles after its handshake, not %0d",
                                    i, out_cycle[i] - hs_cycle[i], latency));
            end
            if (!random_ready && i > 0 && out_cycle[i] != out_cycle[i-1] + 1) begin
                abort_run($sformatf("output %0d did not follow the one before it directly", i));
            end
        end
    endtask

    task automatic run_phase(input logic random_ready);
        hs_cycle.delete();
        out_cycle.delete();
        out_sum.delete();
        fork
            drive_tuples();
            collect_sums(num_tuples, random_ready);
        join
        expect_idle();
        check_phase(random_ready);
    endtask

    initial begin
        rst_n      = 1'b0;
        sink_valid = 1'b0;
        sink_data  = '0;
        src_ready  = 1'b0;
        saw_full   = 1'b0;
        void'($urandom(87));

        load_stimulus();

        repeat (3) @(posedge aclk);
        rst_n <= 1'b1;

        // Quiet outputs straight after reset and input open one cycle later
        @(posedge aclk);
        check_bit("src_valid", 1'b0, src_valid);
        @(posedge aclk);
        check_bit("src_valid", 1'b0, src_valid);
        check_bit("sink_ready", 1'b1, sink_ready);

        // Output always ready in phase one and stalled at random in phase two
        run_phase(1'b0);
        run_phase(1'b1);

        if (saw_full) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("sink_ready never fell while the output stream was stalled");
        end
    end

endmodule

//--- test/user_logic_c0_chk.sv
`timescale 1ns/10ps

module user_logic_c0_chk
    import tuple_pkg::*;
(
    input logic                   aclk,
    input logic                   rst_n,
    input logic                   sink_ready,
    input logic                   src_valid,
    input logic                   src_ready,
    input logic [field_width-1:0] src_data
);

    // Output stream stays idle in the first cycle out of reset
    a_idle_after_reset: assert property (
        @(posedge aclk) $rose(rst_n) |=> !src_valid
    ) else $error("src_valid high in the first cycle after reset");

    // A stalled beat holds its valid and its data
    a_src_hold: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (src_valid && !src_ready) |=> (src_valid && $stable(src_data))
    ) else $error("src_valid or src_data changed while src_ready was low");

    a_sink_ready_known: assert property (
        @(posedge aclk) disable iff (!rst_n) !$isunknown(sink_ready)
    ) else $error("sink_ready unknown after reset");

endmodule

bind user_logic_c0 user_logic_c0_chk u_chk (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .sink_ready (sink_ready),
    .src_valid  (src_valid),
    .src_ready  (src_ready),
    .src_data   (src_data)
);

//--- design/user_logic_c0.sv
`timescale 1ns/10ps

module user_logic_c0
    import tuple_pkg::*;
#(
    parameter int lanes = tuple_lanes
) (
    input  logic                   aclk,
    input  logic                   rst_n,

    // Host input stream, one tuple per beat
    input  logic                   sink_valid,
    output logic                   sink_ready,
    input  logic [tuple_width-1:0] sink_data,

    // Host output stream, one sum per beat
    output logic                   src_valid,
    input  logic                   src_ready,
    output logic [field_width-1:0] src_data
);

    logic                   tup_valid;
    logic                   tup_ready;
    logic [tuple_width-1:0] tup_data;
    tuple_word_u            tup_word;

    logic                   sum_valid;
    logic                   sum_ready;
    field_t                 sum_data;

    // Flat bus word seen lane by lane by the reducer
    assign tup_word.raw = tup_data;

    // Input boundary register
    axis_reg_slice #(
        .data_width (tuple_width)
    ) in_slice (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (sink_valid),
        .in_ready  (sink_ready),
        .in_data   (sink_data),
        .out_valid (tup_valid),
        .out_ready (tup_ready),
        .out_data  (tup_data)
    );

    tuple_sum_pipe #(
        .lanes (lanes)
    ) u_sum (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (tup_valid),
        .in_ready  (tup_ready),
        .in_data   (tup_word),
        .out_valid (sum_valid),
        .out_ready (sum_ready),
        .out_sum   (sum_data)
    );

    // Output boundary register
    axis_reg_slice #(
        .data_width (field_width)
    ) out_slice (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (sum_valid),
        .in_ready  (sum_ready),
        .in_data   (sum_data),
        .out_valid (src_valid),
        .out_ready (src_ready),
        .out_data  (src_data)
    );

endmodule

//--- design/tuple_sum_pipe.sv
`timescale 1ns/10ps

module tuple_sum_pipe
    import tuple_pkg::*;
#(
    parameter int lanes = tuple_lanes
) (
    input  logic        aclk,
    input  logic        rst_n,

    input  logic        in_valid,
    output logic        in_ready,
    input  tuple_word_u in_data,

    output logic        out_valid,
    input  logic        out_ready,
    output field_t      out_sum
);

    // One adder level per stage
    localparam int levels = $clog2(lanes);

    // All partial sums of the tree in one array
    // Level l starts at node lanes - (lanes >> l) and holds lanes >> (l + 1) sums,
    // so the final sum sits in the last node
    localparam int nodes = lanes - 1;

    if ((1 << levels) != lanes || lanes < 2) begin : g_lanes_pow2
        $error("tuple_sum_pipe: lanes must be a power of two of at least 2");
    end

    if (lanes > tuple_lanes) begin : g_lanes_max
        $error("tuple_sum_pipe: lanes exceeds the fields of one tuple");
    end

    logic [levels-1:0] vld_q;
    field_t            node_q [nodes];
    logic              advance;

    // Whole tree moves together when the last stage can hand off
    assign advance   = !vld_q[levels-1] || out_ready;
    assign in_ready  = advance;

    assign out_valid = vld_q[levels-1];
    assign out_sum   = node_q[nodes-1];

    // Valid bit per level, shifted on every advance
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (advance) begin
            vld_q[0] <= in_valid;
            for (int l = 1; l < levels; l++) begin
                vld_q[l] <= vld_q[l-1];
            end
        end
    end

    // First level adds neighbouring fields of the incoming tuple
    always_ff @(posedge aclk) begin
        if (advance) begin
            for (int i = 0; i < lanes / 2; i++) begin
                node_q[i] <= in_data.field[2*i] + in_data.field[2*i+1];
            end
        end
    end

    // Later levels add neighbouring sums of the level before
    for (genvar l = 1; l < levels; l++) begin : g_level
        localparam int base      = lanes - (lanes >> l);
        localparam int prev_base = lanes - (lanes >> (l - 1));
        localparam int width     = lanes >> (l + 1);

        always_ff @(posedge aclk) begin
            if (advance) begin
                for (int i = 0; i < width; i++) begin
                    // Wraps modulo 2^32
                    node_q[base+i] <= node_q[prev_base+2*i] + node_q[prev_base+2*i+1];
                end
            end
        end
    end

endmodule

//--- design/axis_reg_slice.sv
`timescale 1ns/10ps

module axis_reg_slice #(
    parameter int data_width = 32
) (
    input  logic                  aclk,
    input  logic                  rst_n,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [data_width-1:0] in_data,

    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [data_width-1:0] out_data
);

    // Skid entry, holds one beat while the main register stalls
    logic                  skid_valid;
    logic [data_width-1:0] skid_data;

    logic in_fire;
    logic main_free;
    logic skid_valid_nxt;

    assign in_fire   = in_valid && in_ready;
    assign main_free = out_ready || !out_valid;

    // Skid fills when a beat arrives and the main register cannot move,
    // it empties as soon as the main register drains
    always_comb begin
        if (skid_valid) begin
            skid_valid_nxt = !main_free;
        end else begin
            skid_valid_nxt = in_fire && !main_free;
        end
    end

    // Control state
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            if (main_free) begin
                out_valid <= skid_valid || in_fire;
            end
            skid_valid <= skid_valid_nxt;
            // Registered ready, open while the skid entry is free
            in_ready   <= !skid_valid_nxt;
        end
    end

    // Main data register, drains the skid entry first
    always_ff @(posedge aclk) begin
        if (main_free) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (in_fire) begin
                out_data <= in_data;
            end
        end
    end

    // Skid data, captured only when the main register is stalled
    always_ff @(posedge aclk) begin
        if (in_fire && !main_free) begin
            skid_data <= in_data;
        end
    end

endmodule

//--- design/tuple_pkg.sv
package tuple_pkg;

    // Tuple geometry on the host stream
    localparam int tuple_lanes = 16;
    localparam int field_width = 32;
    localparam int tuple_width = tuple_lanes * field_width;

    // One field of a tuple, also the type of the sum
    typedef logic [field_width-1:0] field_t;

    // Input word of the host stream
    // raw is the flat bus word as it arrives from the shell
    // field splits the same bits into lanes, lane 0 in bits 31:0
    typedef union packed {
        logic [tuple_width-1:0]   raw;
        field_t [tuple_lanes-1:0] field;
    } tuple_word_u;

endpackage
